// ==== Makefile ====
# Verilator build and run for the GEM fiber receiver
VERILATOR ?= verilator
TOP       ?= gem_fiber_rx_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps

SRCS := $(shell grep -v '^+' all.f) logic/gem_rx_macros.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(BIN)

$(BIN): all.f $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f all.f

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)

check: run
	@! grep -q "SOME TESTS FAILED" $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== all.f ====
+incdir+logic
logic/gem_rx_pkg.sv
logic/gem_slot_tracker.sv
logic/gem_frame_assembler.sv
logic/gem_link_monitor.sv
logic/gem_fiber_rx.sv
verif/gem_fiber_rx_chk.sv
verif/gem_fiber_rx_tb.sv

// ==== logic/gem_fiber_rx.sv ====
`timescale 1ns/100ps
`include "gem_rx_macros.svh"

module gem_fiber_rx (
    input  logic                     GEM_RX_CLK160,     // Recovered fiber clock
    input  logic                     gem_rx_resetdone,  // Transceiver reset done
    input  logic                     rx_sync_done,      // Phase alignment finished
    input  logic                     ttc_resync,
    input  gem_rx_pkg::rx_word_t     rx_word,
    output logic [`GEM_SLOTS-1:0]    slot_strobe,
    output gem_rx_pkg::frame_t       frame,
    output logic [7:0]               k_char,
    output logic                     overflow,
    output gem_rx_pkg::link_status_t link_status
);

    // ----------------------------------------
    // Common clear
    // ----------------------------------------
    logic                   clear;
    gem_rx_pkg::slot_word_t slot_word;   // Stage 1 to both stage 2 blocks

    // Hold everything while alignment is pending or on resync
    assign clear = !rx_sync_done || ttc_resync;

    // ----------------------------------------
    // Stages
    // ----------------------------------------
    gem_slot_tracker uslot_tracker (
        .GEM_RX_CLK160    (GEM_RX_CLK160),
        .gem_rx_resetdone (gem_rx_resetdone),
        .clear            (clear),
        .rx_word          (rx_word),
        .slot_word        (slot_word),
        .slot_strobe      (slot_strobe)
    );

    // Data path
    gem_frame_assembler uframe_asm (
        .GEM_RX_CLK160    (GEM_RX_CLK160),
        .gem_rx_resetdone (gem_rx_resetdone),
        .clear            (clear),
        .slot_word        (slot_word),
        .frame            (frame),
        .k_char           (k_char),
        .overflow         (overflow)
    );

    // Health path, runs alongside the assembler
    gem_link_monitor ulink_mon (
        .GEM_RX_CLK160    (GEM_RX_CLK160),
        .gem_rx_resetdone (gem_rx_resetdone),
        .clear            (clear),
        .slot_word        (slot_word),
        .link_status      (link_status)
    );

endmodule

// ==== logic/gem_frame_assembler.sv ====
`timescale 1ns/100ps
`include "gem_rx_macros.svh"

module gem_frame_assembler (
    input  logic                   GEM_RX_CLK160,
    input  logic                   gem_rx_resetdone,
    input  logic                   clear,
    input  gem_rx_pkg::slot_word_t slot_word,
    output gem_rx_pkg::frame_t     frame,
    output logic [7:0]             k_char,
    output logic                   overflow
);

    // ----------------------------------------
    // Partial frame
    // ----------------------------------------
    logic [7:0]             w0;     // High byte of the EOF word
    logic [`GEM_WORD_W-1:0] w1;
    logic [`GEM_WORD_W-1:0] w2;
    logic [2:0]             nz;     // Nonzero flags, words 0 to 2
    logic                   lt_q;   // Latency trigger held until slot 3

    assign overflow = (k_char == `GEM_K_OVERFLOW);

    always_ff @(posedge GEM_RX_CLK160 or negedge gem_rx_resetdone) begin
        if (!gem_rx_resetdone) begin
            k_char <= '0;
            w0     <= '0;
            w1     <= '0;
            w2     <= '0;
            nz     <= '0;
            lt_q   <= 1'b0;
            frame  <= '0;
        end else if (clear) begin
            k_char <= '0;
            w0     <= '0;
            w1     <= '0;
            w2     <= '0;
            nz     <= '0;
            lt_q   <= 1'b0;
            frame  <= '0;
        end else begin
            frame <= '0;   // Frame only valid for one clock

            // Lowest slot wins if the chain has several flags
            if (slot_word.slot[0]) begin
                // EOF K-word
                k_char <= slot_word.data[7:0];
                w0     <= slot_word.data[15:8];
                nz[0]  <= |slot_word.data[15:8];
                lt_q   <= slot_word.lt_trg;
            end else if (slot_word.slot[1]) begin
                w1    <= slot_word.data;   // First word after EOF
                nz[1] <= |slot_word.data;
            end else if (slot_word.slot[2]) begin
                w2    <= slot_word.data;
                nz[2] <= |slot_word.data;
            end else if (slot_word.slot[3]) begin
                // Last word goes straight into the top of the frame
                frame.data       <= {slot_word.data, w2, w1, w0};
                frame.nonzero    <= {|slot_word.data, nz};
                frame.ltncy_trig <= lt_q;
            end
        end
    end

endmodule

// ==== logic/gem_link_monitor.sv ====
`timescale 1ns/100ps
`include "gem_rx_macros.svh"

module gem_link_monitor (
    input  logic                     GEM_RX_CLK160,
    input  logic                     gem_rx_resetdone,
    input  logic                     clear,
    input  gem_rx_pkg::slot_word_t   slot_word,
    output gem_rx_pkg::link_status_t link_status
);

    // ----------------------------------------
    // Monitor state
    // ----------------------------------------
    logic [`GEM_SLOTS-1:0] mon_in;      // Health of each slot, last BX
    logic                  mon_rst;     // Last BX not clean
    logic [3:0]            mon_count;   // Clean frames so far
    logic [7:0]            err_count;
    logic                  link_good;
    logic                  link_err;    // Sticky, link was up then dropped
    logic                  went_down;

    assign went_down = link_good && mon_rst;

    always_ff @(posedge GEM_RX_CLK160 or negedge gem_rx_resetdone) begin
        if (!gem_rx_resetdone) begin
            mon_in    <= '0;
            mon_rst   <= 1'b1;   // Link counts as not yet alive
            mon_count <= '0;
            err_count <= '0;
            link_good <= 1'b0;
            link_err  <= 1'b0;
        end else if (clear) begin
            mon_in    <= '0;
            mon_rst   <= 1'b1;
            mon_count <= '0;
            err_count <= '0;
            link_good <= 1'b0;
            link_err  <= 1'b0;
        end else begin
            // No slot means no frame phase, so the link is down
            if (slot_word.slot == '0) begin
                mon_in <= '0;
            end else begin
                for (int k = 0; k < `GEM_SLOTS; k++) begin
                    if (slot_word.slot[k]) begin
                        mon_in[k] <= slot_word.word_ok;
                    end
                end
            end

            mon_rst <= (mon_in != '1);   // Any bad slot in the last BX

            // Count clean frames, stop once good
            if (mon_rst) begin
                mon_count <= '0;
            end else if (!link_good && slot_word.slot[3]) begin
                mon_count <= mon_count + 4'd1;
            end

            link_good <= !mon_rst && (mon_count == `GEM_GOOD_FRAMES);

            // ----------------------------------------
            // Loss tracking
            // ----------------------------------------
            if (went_down) begin
                link_err <= 1'b1;
            end
            if (went_down && (err_count[7:4] != `GEM_ERR_SAT_NIBBLE)) begin
                err_count <= err_count + 8'd1;   // Saturates at E0
            end
        end
    end

    // Status outputs
    always_comb begin
        link_status.link_good    = link_good;
        link_status.link_had_err = link_err || mon_rst;   // Also high before first lock
        link_status.link_bad     = err_count[7];
        link_status.errcount     = err_count;
    end

endmodule

// ==== logic/gem_rx_macros.svh ====
`ifndef GEM_RX_MACROS_SVH
`define GEM_RX_MACROS_SVH

// ----------------------------------------
// Data path widths
// ----------------------------------------
`define GEM_WORD_W        16      // Decoded 8b10b word, two bytes
`define GEM_FRAME_W       56      // w3 + w2 + w1 + high byte of w0
`define GEM_SLOTS         4       // Words per bunch crossing

// ----------------------------------------
// K-codes
// ----------------------------------------
// GEM cycles bc, f7, fb, fd as end-of-frame markers
// and sends fc on overflow
//   bc = 1011_1100
//   fc = 1111_1100
// Every legal marker has bits 7, 5 and 4 set
`define GEM_K_EOF_MASK    8'hB0   // Bits 7, 5, 4
`define GEM_K_OVERFLOW    8'hFC   // Overflow marker, also the latency trigger

// ----------------------------------------
// Link monitor limits
// ----------------------------------------
// Link is called good after 1 + 15 clean frames
`define GEM_GOOD_FRAMES   4'd15

// Loss counter holds once upper nibble hits E,
// so bit 7 stays set as the link-bad flag
`define GEM_ERR_SAT_NIBBLE 4'hE

`endif

// ==== logic/gem_rx_pkg.sv ====
`include "gem_rx_macros.svh"

package gem_rx_pkg;

    // ----------------------------------------
    // Raw word from the 8b10b decoder
    // ----------------------------------------
    typedef struct packed {
        logic [`GEM_WORD_W-1:0] data;        // Low byte carries the K-code on a comma
        logic [1:0]             isk;         // Per-byte K flags
        logic [1:0]             notintable;  // Per-byte decode errors
        logic                   lossofsync;  // Decoder lost comma lock
    } rx_word_t;

    // ----------------------------------------
    // Word after slot tagging
    // ----------------------------------------
    typedef struct packed {
        logic [`GEM_WORD_W-1:0] data;
        logic [`GEM_SLOTS-1:0]  slot;        // Bit k = slot k; zero between frames
        logic                   word_ok;     // Healthy for its slot, single flag
        logic                   lt_trg;      // Slot 0 K-code was overflow
    } slot_word_t;

    // ----------------------------------------
    // Assembled bunch-crossing frame
    // ----------------------------------------
    typedef struct packed {
        logic [`GEM_FRAME_W-1:0] data;       // {w3, w2, w1, w0[15:8]}
        logic [`GEM_SLOTS-1:0]   nonzero;    // Per-word nonzero flags
        logic                    ltncy_trig;
    } frame_t;

    // Link health summary
    typedef struct packed {
        logic       link_good;     // 16 clean frames seen
        logic       link_had_err;  // Sticky loss, or never up
        logic       link_bad;      // errcount bit 7
        logic [7:0] errcount;      // Times the link went down
    } link_status_t;

endpackage

// ==== logic/gem_slot_tracker.sv ====
`timescale 1ns/100ps
`include "gem_rx_macros.svh"

module gem_slot_tracker (
    input  logic                   GEM_RX_CLK160,
    input  logic                   gem_rx_resetdone,
    input  logic                   clear,          // Sync lost or resync
    input  gem_rx_pkg::rx_word_t   rx_word,
    output gem_rx_pkg::slot_word_t slot_word,
    output logic [`GEM_SLOTS-1:0]  slot_strobe
);

    // ----------------------------------------
    // Slot chain
    // ----------------------------------------
    logic [`GEM_SLOTS-1:0] slot_chain;   // Slot of the word now at the input
    logic                  comma;
    logic                  one_slot;
    logic                  eof_ok;
    logic                  data_ok;
    logic                  word_ok;
    logic                  lt_trg;

    assign comma = (rx_word.isk == 2'b01);   // K-word in low byte only

    // Comma starts the chain; slot 1 follows next clock
    always_ff @(posedge GEM_RX_CLK160 or negedge gem_rx_resetdone) begin
        if (!gem_rx_resetdone) begin
            slot_chain <= '0;
        end else if (clear) begin
            slot_chain <= '0;
        end else begin
            slot_chain[1] <= comma;
            slot_chain[2] <= slot_chain[1];
            slot_chain[3] <= slot_chain[2];
            slot_chain[0] <= slot_chain[3];   // Four after comma, next EOF word
        end
    end

    // ----------------------------------------
    // Word health
    // ----------------------------------------
    // Overlapping commas leave several flags in the chain
    assign one_slot = $onehot(slot_chain);

    // Slot 0 must be a legal EOF K-word
    assign eof_ok = !rx_word.lossofsync
                 && (rx_word.isk == 2'b01)
                 && (rx_word.notintable == 2'b00)
                 && ((rx_word.data[7:0] & `GEM_K_EOF_MASK) == `GEM_K_EOF_MASK);

    // Data slots carry no K bits
    assign data_ok = !rx_word.lossofsync
                  && (rx_word.notintable == 2'b00)
                  && (rx_word.isk == 2'b00);

    assign word_ok = one_slot && (slot_chain[0] ? eof_ok : data_ok);

    // Overflow K-code doubles as latency trigger
    assign lt_trg = slot_chain[0] && comma && (rx_word.data[7:0] == `GEM_K_OVERFLOW);

    // ----------------------------------------
    // Output register
    // ----------------------------------------
    always_ff @(posedge GEM_RX_CLK160 or negedge gem_rx_resetdone) begin
        if (!gem_rx_resetdone) begin
            slot_word <= '0;
        end else if (clear) begin
            slot_word <= '0;
        end else begin
            slot_word.data    <= rx_word.data;
            slot_word.slot    <= slot_chain;   // Tag travels with its word
            slot_word.word_ok <= word_ok;
            slot_word.lt_trg  <= lt_trg;
        end
    end

    assign slot_strobe = slot_word.slot;   // Frame-phase strobes, aligned to slot_word

endmodule

// ==== verif/gem_fiber_rx_chk.sv ====
`timescale 1ns/100ps
`include "gem_rx_macros.svh"

module gem_fiber_rx_chk (
    input logic                     GEM_RX_CLK160,
    input logic                     gem_rx_resetdone,
    input logic [`GEM_SLOTS-1:0]    slot_strobe,
    input gem_rx_pkg::frame_t       frame,
    input logic [7:0]               k_char,
    input logic                     overflow,
    input gem_rx_pkg::link_status_t link_status
);

    // ----------------------------------------
    // Frame phase
    // ----------------------------------------
    // Regular frames never overlap in the chain
    a_one_phase : assert property (@(posedge GEM_RX_CLK160) disable iff (!gem_rx_resetdone)
        $onehot0(slot_strobe))
        else $error("slot_strobe has several phases set: %b", slot_strobe);

    // Frame only lives on the slot-0 strobe
    a_frame_phase : assert property (@(posedge GEM_RX_CLK160) disable iff (!gem_rx_resetdone)
        (frame != '0) |-> slot_strobe[0])
        else $error("frame nonzero outside slot 0 strobe");

    // ----------------------------------------
    // Flags
    // ----------------------------------------
    a_overflow : assert property (@(posedge GEM_RX_CLK160) disable iff (!gem_rx_resetdone)
        overflow == (k_char == `GEM_K_OVERFLOW))
        else $error("overflow %b disagrees with k_char %h", overflow, k_char);

    a_link_bad : assert property (@(posedge GEM_RX_CLK160) disable iff (!gem_rx_resetdone)
        link_status.link_bad == link_status.errcount[7])   // Bad flag is just bit 7
        else $error("link_bad disagrees with errcount %h", link_status.errcount);

endmodule

// ==== verif/gem_fiber_rx_tb.sv ====
`timescale 1ns/100ps
`include "gem_rx_macros.svh"

module gem_fiber_rx_tb;

    logic                     GEM_RX_CLK160;
    logic                     gem_rx_resetdone;
    logic                     rx_sync_done;
    logic                     ttc_resync;
    gem_rx_pkg::rx_word_t     rx_word;
    logic [`GEM_SLOTS-1:0]    slot_strobe;
    gem_rx_pkg::frame_t       frame;
    logic [7:0]               k_char;
    logic                     overflow;
    gem_rx_pkg::link_status_t status;

    integer seed = 32'h6d97_8c5c;
    int     errors = 0;
    int     checks = 0;
    int     frames_seen = 0;                // Frames actually compared

    gem_rx_pkg::frame_t exp_q[$];           // Expected frames, in order
    logic               use_q[$];           // Whether that frame is comparable
    logic               next_cmp = 1'b0;    // First frame after clear has a stale w0

    gem_fiber_rx dut0 (
        .GEM_RX_CLK160    (GEM_RX_CLK160),
        .gem_rx_resetdone (gem_rx_resetdone),
        .rx_sync_done     (rx_sync_done),
        .ttc_resync       (ttc_resync),
        .rx_word          (rx_word),
        .slot_strobe      (slot_strobe),
        .frame            (frame),
        .k_char           (k_char),
        .overflow         (overflow),
        .link_status      (status)
    );

    bind gem_fiber_rx gem_fiber_rx_chk chk0 (
        .GEM_RX_CLK160    (GEM_RX_CLK160),
        .gem_rx_resetdone (gem_rx_resetdone),
        .slot_strobe      (slot_strobe),
        .frame            (frame),
        .k_char           (k_char),
        .overflow         (overflow),
        .link_status      (link_status)
    );

    always #4 GEM_RX_CLK160 = ~GEM_RX_CLK160;   // 125 MHz stand-in for 160

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // Comma with K-code, then three data words
    // bad picks a data word with a decode error, zmask forces words to zero
    task automatic send_frame(input logic [7:0] kcode, input int bad, input logic [3:0] zmask);
        gem_rx_pkg::rx_word_t w;
        gem_rx_pkg::frame_t   e;
        logic [15:0]          d [4];
        logic [31:0]          r;
        logic [7:0]           hi;
        r  = $random(seed);
        hi = zmask[0] ? 8'h00 : r[15:8];
        d[0] = {hi, kcode};
        for (int k = 1; k < 4; k++) begin
            r    = $random(seed);
            d[k] = zmask[k] ? 16'h0000 : r[15:0];
        end
        for (int k = 0; k < 4; k++) begin
            @(posedge GEM_RX_CLK160);
            w      = '0;
            w.data = d[k];
            w.isk  = (k == 0) ? 2'b01 : 2'b00;
            if (bad == k && k != 0) begin
                w.notintable = 2'b01;   // Low byte not in table
            end
            rx_word <= w;
        end
        e.data       = {d[3], d[2], d[1], hi};
        e.nonzero    = {|d[3], |d[2], |d[1], |hi};
        e.ltncy_trig = (kcode == `GEM_K_OVERFLOW);
        exp_q.push_back(e);
        use_q.push_back(next_cmp);
        next_cmp = 1'b1;
    endtask

    // Keep healthy frames flowing until link_good reaches want
    task automatic frames_until(input logic want, input int max_frames);
        int n;
        n = 0;
        while (status.link_good !== want && n < max_frames) begin
            send_frame(8'hBC, 0, 4'b0000);
            @(negedge GEM_RX_CLK160);
            n++;
        end
        if (status.link_good !== want) begin
            errors++;
            $display("timeout at %0t: link_good did not become %0d within %0d frames",
                     $time, want, max_frames);
        end
    endtask

    // One clock of ttc_resync, idle line, expected frames dropped
    task automatic pulse_resync();
        @(posedge GEM_RX_CLK160);
        ttc_resync <= 1'b1;
        rx_word    <= '0;   // Idle during clear
        @(posedge GEM_RX_CLK160);
        ttc_resync <= 1'b0;
        exp_q.delete();     // Frame in flight is dropped
        use_q.delete();
        next_cmp = 1'b0;
        @(negedge GEM_RX_CLK160);
    endtask

    // Frame leaves on slot-0 strobe, compare with the oldest sent frame
    always @(negedge GEM_RX_CLK160) begin
        if (gem_rx_resetdone && slot_strobe[0]) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("frame strobe at %0t with no frame sent", $time);
            end else begin
                if (use_q[0]) begin
                    check("frame", 64'(frame), 64'(exp_q[0]));
                    frames_seen++;
                end
                void'(exp_q.pop_front());
                void'(use_q.pop_front());
            end
        end
    end

    // ----------------------------------------
    // Tests
    // ----------------------------------------
    task automatic frame_assembly_test();
        for (int i = 0; i < 7; i++) begin
            send_frame(8'hBC, 0, (i == 3) ? 4'b0101 : 4'b0000);   // One frame with zero words
            @(negedge GEM_RX_CLK160);
            check("slot_strobe", 64'(slot_strobe), 64'h4);   // Second data word in stage 1
        end
        check("frames_compared", 64'(frames_seen), 64'd5);   // First stale, last pending
    endtask

    task automatic overflow_test();
        send_frame(8'hFC, 0, 4'b0000);
        @(negedge GEM_RX_CLK160);
        check("k_char", 64'(k_char), 64'hFC);
        check("overflow", 64'(overflow), 64'd1);
        send_frame(8'hBC, 0, 4'b0000);   // Frame monitor sees ltncy_trig of the FC frame here
        @(negedge GEM_RX_CLK160);
        check("k_char", 64'(k_char), 64'hBC);
        check("overflow", 64'(overflow), 64'd0);
    endtask

    task automatic link_up_test();
        frames_until(1'b1, 40);
        check("errcount", 64'(status.errcount), 64'd0);
        check("link_had_err", 64'(status.link_had_err), 64'd0);
    endtask

    task automatic link_loss_test();
        send_frame(8'hBC, 2, 4'b0000);
        frames_until(1'b0, 4);
        check("errcount", 64'(status.errcount), 64'd1);
        check("link_had_err", 64'(status.link_had_err), 64'd1);
        frames_until(1'b1, 40);
        check("link_had_err", 64'(status.link_had_err), 64'd1);   // Sticky
    endtask

    task automatic saturation_test();
        int n;
        n = 0;
        while (status.errcount[7:4] != `GEM_ERR_SAT_NIBBLE && n < 240) begin
            send_frame(8'hBC, 1, 4'b0000);
            frames_until(1'b0, 4);
            frames_until(1'b1, 40);
            n++;
        end
        if (status.errcount[7:4] != `GEM_ERR_SAT_NIBBLE) begin
            errors++;
            $display("timeout: errcount never reached its saturation value");
        end
        check("errcount", 64'(status.errcount), 64'hE0);
        check("link_bad", 64'(status.link_bad), 64'd1);
        send_frame(8'hBC, 3, 4'b0000);   // One more loss, count must hold
        frames_until(1'b0, 4);
        check("errcount", 64'(status.errcount), 64'hE0);
        check("link_bad", 64'(status.link_bad), 64'd1);
    endtask

    task automatic resync_test();
        frames_until(1'b1, 40);   // Link up again, so the clear has to drop it
        pulse_resync();
        check("errcount", 64'(status.errcount), 64'd0);
        check("link_good", 64'(status.link_good), 64'd0);
        check("link_had_err", 64'(status.link_had_err), 64'd1);
        check("frame", 64'(frame), 64'd0);
        frames_until(1'b1, 40);
        check("errcount", 64'(status.errcount), 64'd0);
        check("link_had_err", 64'(status.link_had_err), 64'd0);
        pulse_resync();           // Clean link, clear alone raises link_had_err
        check("link_good", 64'(status.link_good), 64'd0);
        check("link_had_err", 64'(status.link_had_err), 64'd1);
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        GEM_RX_CLK160    = 1'b0;
        gem_rx_resetdone = 1'b0;
        rx_sync_done     = 1'b1;
        ttc_resync       = 1'b0;
        rx_word          = '0;
        repeat (5) @(posedge GEM_RX_CLK160);
        gem_rx_resetdone <= 1'b1;

        frame_assembly_test();
        overflow_test();
        link_up_test();
        link_loss_test();
        saturation_test();
        resync_test();

        @(posedge GEM_RX_CLK160);
        rx_word <= '0;
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Watchdog for a stuck run
    initial begin
        #2_000_000;
        $display("simulation ran past its time limit");
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule
